//--- verilog/mel_pkg.sv
`default_nettype none

package mel_pkg;

    localparam int n_bins     = 64;     // bins per frame
    localparam int n_bands    = 8;      // bands leaving per frame
    localparam int weight_one = 32768;  // q15 unity, filter peak
    localparam int power_w    = 32;
    localparam int weight_w   = 16;
    localparam int energy_w   = 32;
    localparam int log_w      = 16;
    localparam int q_frac     = 15;     // fraction bits of a weight
    localparam int log_frac   = 3;      // fraction bits of a log value

    typedef logic [5:0]          bin_idx_t;
    typedef logic [3:0]          band_idx_t;
    typedef logic [power_w-1:0]  power_t;
    typedef logic [weight_w-1:0] weight_t;
    typedef logic [energy_w-1:0] energy_t;
    typedef logic [log_w-1:0]    log_t;   // 8 * log2

    //////////////////////////////////////////////////
    // rising ramps, each ending on unity
    // boundaries at 3 7 12 18 25 33 42 52 63
    //////////////////////////////////////////////////
    localparam weight_t weight_table [n_bins] = '{
        16'd8192,  16'd16384, 16'd24576, 16'd32768,                      // L=4
        16'd8192,  16'd16384, 16'd24576, 16'd32768,                      // L=4
        16'd6554,  16'd13107, 16'd19661, 16'd26214, 16'd32768,           // L=5
        16'd5461,  16'd10923, 16'd16384, 16'd21845, 16'd27307,
        16'd32768,                                                       // L=6
        16'd4681,  16'd9362,  16'd14043, 16'd18725, 16'd23406,
        16'd28087, 16'd32768,                                            // L=7
        16'd4096,  16'd8192,  16'd12288, 16'd16384, 16'd20480,
        16'd24576, 16'd28672, 16'd32768,                                 // L=8
        16'd3641,  16'd7282,  16'd10923, 16'd14564, 16'd18204,
        16'd21845, 16'd25486, 16'd29127, 16'd32768,                      // L=9
        16'd3277,  16'd6554,  16'd9830,  16'd13107, 16'd16384,
        16'd19661, 16'd22938, 16'd26214, 16'd29491, 16'd32768,           // L=10
        16'd2979,  16'd5958,  16'd8937,  16'd11916, 16'd14895,
        16'd17873, 16'd20852, 16'd23831, 16'd26810, 16'd29789,
        16'd32768                                                        // L=11
    };

endpackage

`default_nettype wire

//--- verilog/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // one spectrum bin on the input stream
    typedef struct packed {
        mel_pkg::power_t power;
    } bin_beat_t;

    // decode to execute
    typedef struct packed {
        mel_pkg::power_t  power;
        mel_pkg::energy_t product;    // (power * weight) >> 15
        logic             boundary;   // weight is unity
        logic             frame_end;  // bin 63
    } weighted_beat_t;

    // execute to result, one per boundary
    typedef struct packed {
        mel_pkg::energy_t energy;
        logic             frame_end;
    } band_beat_t;

    // band 0 sits in the low word
    typedef struct packed {
        mel_pkg::log_t [mel_pkg::n_bands-1:0] band;
    } frame_result_t;

endpackage

`default_nettype wire

//--- verilog/mel_weight_seq.sv
`timescale 1ns/1ps
`default_nettype none

module mel_weight_seq (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  stream_pkg::bin_beat_t      in_beat,
    output logic                       out_valid,
    output stream_pkg::weighted_beat_t out_beat
);

    mel_pkg::bin_idx_t bin_cnt;   // position inside the frame
    mel_pkg::weight_t  weight;
    logic [mel_pkg::power_w+mel_pkg::weight_w-1:0] full_prod;

    assign weight    = mel_pkg::weight_table[bin_cnt];
    assign full_prod = in_beat.power * weight;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            bin_cnt   <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid)
                bin_cnt <= bin_cnt + 1'b1;  // wraps to 0 after bin 63
        end
    end

    // payload, only loaded on an accepted bin
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_beat.power     <= in_beat.power;
            out_beat.product   <= mel_pkg::energy_t'(full_prod >> mel_pkg::q_frac);
            out_beat.boundary  <= (weight == mel_pkg::weight_t'(mel_pkg::weight_one));
            out_beat.frame_end <= (bin_cnt == mel_pkg::bin_idx_t'(mel_pkg::n_bins - 1));
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // counter returns to bin 0 only on the beat that closes the frame
    wrap_after_frame_end: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && $past(bin_cnt) == mel_pkg::bin_idx_t'(mel_pkg::n_bins - 1)
            && bin_cnt == '0)
        |-> (out_valid && out_beat.frame_end));

endmodule

`default_nettype wire

//--- verilog/mel_accumulate.sv
`timescale 1ns/1ps
`default_nettype none

module mel_accumulate (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  stream_pkg::weighted_beat_t in_beat,
    output logic                       out_valid,
    output stream_pkg::band_beat_t     out_beat
);

    //////////////////////////////////////////////////
    // product register
    //////////////////////////////////////////////////

    logic                       p_valid;
    stream_pkg::weighted_beat_t p_beat;

    always_ff @(posedge clk) begin
        if (reset)
            p_valid <= 1'b0;
        else
            p_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            p_beat <= in_beat;
    end

    //////////////////////////////////////////////////
    // rising and falling sums
    //////////////////////////////////////////////////

    mel_pkg::energy_t rise_sum;   // left side of the next filter
    mel_pkg::energy_t fall_sum;   // right side of the current filter
    mel_pkg::energy_t inverse;    // power minus weighted power
    mel_pkg::energy_t rise_next;

    assign inverse   = p_beat.power - p_beat.product;
    assign rise_next = rise_sum + p_beat.product;

    always_ff @(posedge clk) begin
        if (reset) begin
            rise_sum  <= '0;
            fall_sum  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= p_valid && p_beat.boundary;
            if (p_valid) begin
                if (p_beat.boundary) begin
                    rise_sum <= '0;
                    fall_sum <= rise_next;  // peak bin closes the rising side
                end else begin
                    rise_sum <= rise_next;
                    fall_sum <= fall_sum + inverse;
                end
            end
        end
    end

    // band leaves with the falling sum as it stood
    always_ff @(posedge clk) begin
        if (p_valid && p_beat.boundary) begin
            out_beat.energy    <= fall_sum;
            out_beat.frame_end <= p_beat.frame_end;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // every band traces back to a unity weight two edges earlier
    band_from_boundary: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> ($past(in_valid, 2) && $past(in_beat.boundary, 2)));

endmodule

`default_nettype wire

//--- verilog/mel_band_collect.sv
`timescale 1ns/1ps
`default_nettype none

module mel_band_collect (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  stream_pkg::band_beat_t    in_beat,
    output logic                      m_valid,
    input  logic                      m_ready,
    output stream_pkg::frame_result_t m_data,
    output logic                      frame_done
);

    typedef enum logic {
        collect,
        hold
    } state_t;

    state_t             state;
    mel_pkg::band_idx_t band_cnt;   // emissions seen this frame, first is dropped
    logic [2:0]         band_slot;
    mel_pkg::log_t      band_log;

    //////////////////////////////////////////////////
    // log conversion
    //////////////////////////////////////////////////

    // 8 * msb index plus the three bits under it
    function automatic mel_pkg::log_t log_of(mel_pkg::energy_t e);
        logic [4:0]                   p;
        logic [mel_pkg::log_frac-1:0] frac;
        p    = '0;
        frac = '0;
        for (int i = 0; i < mel_pkg::energy_w; i++) begin
            if (e[i])
                p = 5'(i);
        end
        if (p >= 5'(mel_pkg::log_frac))
            frac = mel_pkg::log_frac'(e >> (p - 5'(mel_pkg::log_frac)));
        if (e == '0)
            return '0;
        return mel_pkg::log_t'({p, frac});
    endfunction

    assign band_log  = log_of(in_beat.energy);
    assign band_slot = 3'(band_cnt - 1'b1);
    assign m_valid   = (state == hold);

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= collect;
            band_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                collect: begin
                    if (in_valid) begin
                        if (in_beat.frame_end) begin
                            band_cnt <= '0;
                            state    <= hold;
                        end else begin
                            band_cnt <= band_cnt + 1'b1;
                        end
                    end
                end
                hold: begin
                    if (m_ready) begin   // handshake
                        state      <= collect;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= collect;
            endcase
        end
    end

    // result words, only written while collecting
    always_ff @(posedge clk) begin
        if (state == collect && in_valid && band_cnt != '0)
            m_data.band[band_slot] <= band_log;
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    result_stable: assert property (@(posedge clk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

    // input is closed while a frame waits, so nothing can land here
    no_band_in_hold: assert property (@(posedge clk) disable iff (reset)
        (state == hold) |-> !in_valid);

endmodule

`default_nettype wire

//--- verilog/mel_filter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mel_filter_bank (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  stream_pkg::bin_beat_t     s_data,
    output logic                      m_valid,
    input  logic                      m_ready,
    output stream_pkg::frame_result_t m_data
);

    logic                       accept;
    logic                       last_accept;   // bin 63 taken
    logic                       frame_pending;
    logic                       frame_done;
    mel_pkg::bin_idx_t          accept_cnt;
    logic                       dec_valid;
    stream_pkg::weighted_beat_t dec_beat;
    logic                       acc_valid;
    stream_pkg::band_beat_t     acc_beat;

    assign accept      = s_valid && s_ready;
    assign last_accept = accept && (accept_cnt == mel_pkg::bin_idx_t'(mel_pkg::n_bins - 1));

    //////////////////////////////////////////////////
    // input flow control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            s_ready       <= 1'b0;
            frame_pending <= 1'b0;
            accept_cnt    <= '0;
        end else begin
            if (accept)
                accept_cnt <= accept_cnt + 1'b1;
            if (last_accept) begin
                s_ready       <= 1'b0;   // closed until the result is taken
                frame_pending <= 1'b1;
            end else if (frame_done) begin
                s_ready       <= 1'b1;
                frame_pending <= 1'b0;
            end else begin
                s_ready <= !frame_pending;
            end
        end
    end

    mel_weight_seq u_weight_seq (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (accept),
        .in_beat   (s_data),
        .out_valid (dec_valid),
        .out_beat  (dec_beat)
    );

    mel_accumulate u_accumulate (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_beat   (dec_beat),
        .out_valid (acc_valid),
        .out_beat  (acc_beat)
    );

    mel_band_collect u_band_collect (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (acc_valid),
        .in_beat    (acc_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_data     (m_data),
        .frame_done (frame_done)
    );

    // m_valid goes high on the third edge after the one that takes bin 63
    frame_latency: assert property (@(posedge clk) disable iff (reset)
        last_accept |-> ##4 $rose(m_valid));

endmodule

`default_nettype wire

//--- sim/tb_mel_filter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mel_filter_bank;

    localparam int clk_period      = 4;
    localparam int frames_total    = 13;   // every frame the tests send, partial one included
    localparam int watchdog_cycles = frames_total * 200;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      s_valid;
    logic                      s_ready;
    stream_pkg::bin_beat_t     s_data;
    logic                      m_valid;
    logic                      m_ready;
    stream_pkg::frame_result_t m_data;

    mel_pkg::power_t frame_bins [mel_pkg::n_bins];   // bins of the frame being sent

    always #(clk_period / 2) clk = ~clk;

    mel_filter_bank u_mel_filter_bank (
        .clk     (clk),
        .reset   (reset),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data)
    );

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // 8 * msb index, plus the three bits under the msb
    function automatic mel_pkg::log_t ref_log(mel_pkg::energy_t e);
        int msb;
        int frac;
        msb  = -1;
        frac = 0;
        for (int i = 0; i < mel_pkg::energy_w; i++) begin
            if (e[i])
                msb = i;
        end
        if (msb < 0)
            return '0;
        if (msb >= 3)
            frac = int'((e >> (msb - 3)) & 32'd7);
        return mel_pkg::log_t'(8 * msb + frac);
    endfunction

    function automatic stream_pkg::frame_result_t ref_frame();
        stream_pkg::frame_result_t res;
        longint                    rise;
        longint                    fall;
        longint                    prod;
        int                        emitted;
        res     = '0;
        rise    = 0;
        fall    = 0;
        emitted = 0;
        for (int b = 0; b < mel_pkg::n_bins; b++) begin
            prod = (longint'(frame_bins[b]) * longint'(mel_pkg::weight_table[b])) >> 15;
            if (mel_pkg::weight_table[b] == mel_pkg::weight_t'(mel_pkg::weight_one)) begin
                if (emitted > 0)   // first emission is the empty falling side
                    res.band[emitted - 1] = ref_log(mel_pkg::energy_t'(fall));
                emitted++;
                fall = rise + prod;
                rise = 0;
            end else begin
                rise += prod;
                fall += longint'(frame_bins[b]) - prod;
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_frame(input stream_pkg::frame_result_t got,
                               input stream_pkg::frame_result_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp)
            stop_on_error($sformatf("FAIL %0t: %s took %0d cycles, expected %0d",
                                    $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #1;   // inputs move just after the edge
    endtask

    task automatic apply_reset(input int cycles);
        reset   = 1'b1;
        s_valid = 1'b0;
        repeat (cycles) begin
            next_cycle();
            check_flag(m_valid, 1'b0, "m_valid during reset");
        end
        reset = 1'b0;
        next_cycle();
        check_flag(s_ready, 1'b1, "s_ready one cycle after reset");
    endtask

    task automatic fill_constant(input mel_pkg::power_t power);
        for (int b = 0; b < mel_pkg::n_bins; b++)
            frame_bins[b] = power;
    endtask

    task automatic fill_random();
        for (int b = 0; b < mel_pkg::n_bins; b++)
            frame_bins[b] = mel_pkg::power_t'($urandom % 32'h0100_0000);   // below 2^24
    endtask

    // sends the first count bins, optionally with idle cycles between them
    task automatic send_bins(input int count, input bit gaps);
        logic taken;
        int   gap_len;
        for (int b = 0; b < count; b++) begin
            if (gaps && ($urandom % 32'd3) == 32'd0) begin
                gap_len = int'($urandom % 32'd3) + 1;
                s_valid = 1'b0;
                repeat (gap_len) next_cycle();
            end
            s_valid      = 1'b1;
            s_data.power = frame_bins[b];
            do begin
                taken = s_ready;   // registered, steady until the next edge
                next_cycle();
            end while (!taken);
        end
        s_valid = 1'b0;
    endtask

    task automatic take_frame(output stream_pkg::frame_result_t got);
        while (m_valid !== 1'b1)
            next_cycle();
        got     = m_data;
        m_ready = 1'b1;
        next_cycle();   // handshake edge
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_zero_frame();
        stream_pkg::frame_result_t got;
        fill_constant('0);
        send_bins(mel_pkg::n_bins, 1'b0);
        take_frame(got);
        check_frame(got, '0, "all-zero frame");
    endtask

    task automatic test_constant_frame();
        stream_pkg::frame_result_t got;
        int                        wait_cycles;
        fill_constant(mel_pkg::power_t'(4096));
        send_bins(mel_pkg::n_bins, 1'b0);
        wait_cycles = 0;   // counted from the edge that took bin 63
        while (m_valid !== 1'b1) begin
            next_cycle();
            wait_cycles++;
        end
        check_latency(wait_cycles, 3, "bin 63 to m_valid");
        take_frame(got);
        check_frame(got, ref_frame(), "constant frame");
    endtask

    task automatic test_random_frames();
        stream_pkg::frame_result_t got;
        for (int f = 0; f < 5; f++) begin
            fill_random();
            send_bins(mel_pkg::n_bins, 1'b0);
            take_frame(got);
            check_frame(got, ref_frame(), $sformatf("random frame %0d", f));
        end
    endtask

    task automatic test_input_gaps();
        stream_pkg::frame_result_t plain;
        stream_pkg::frame_result_t gapped;
        fill_random();
        send_bins(mel_pkg::n_bins, 1'b0);
        take_frame(plain);
        check_frame(plain, ref_frame(), "frame without gaps");
        send_bins(mel_pkg::n_bins, 1'b1);   // same bins again
        take_frame(gapped);
        check_frame(gapped, ref_frame(), "frame with gaps");
    endtask

    task automatic test_backpressure();
        stream_pkg::frame_result_t held;
        stream_pkg::frame_result_t got;
        int                        wait_cycles;
        fill_random();
        m_ready = 1'b0;
        send_bins(mel_pkg::n_bins, 1'b0);
        while (m_valid !== 1'b1)
            next_cycle();
        held = ref_frame();
        check_frame(m_data, held, "held frame");
        repeat (20) begin
            next_cycle();
            check_flag(m_valid, 1'b1, "m_valid under back-pressure");
            check_frame(m_data, held, "m_data under back-pressure");
            check_flag(s_ready, 1'b0, "s_ready while a frame waits");
        end
        m_ready = 1'b1;
        next_cycle();
        check_flag(m_valid, 1'b0, "m_valid after handshake");
        wait_cycles = 0;
        while (s_ready !== 1'b1) begin
            next_cycle();
            wait_cycles++;
        end
        check_latency(wait_cycles, 1, "handshake to s_ready");
        fill_random();
        send_bins(mel_pkg::n_bins, 1'b0);
        take_frame(got);
        check_frame(got, ref_frame(), "frame after back-pressure");
    endtask

    task automatic test_reset_mid_frame();
        stream_pkg::frame_result_t got;
        fill_random();
        send_bins(30, 1'b0);
        apply_reset(5);
        repeat (8) begin
            next_cycle();
            check_flag(m_valid, 1'b0, "m_valid after mid-frame reset");
        end
        fill_random();
        send_bins(mel_pkg::n_bins, 1'b0);
        take_frame(got);
        check_frame(got, ref_frame(), "frame after mid-frame reset");
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset   = 1'b1;
        s_valid = 1'b0;
        s_data  = '0;
        m_ready = 1'b1;
        void'($urandom(202));
        apply_reset(5);
        test_zero_frame();
        test_constant_frame();
        test_random_frames();
        test_input_gaps();
        test_backpressure();
        test_reset_mid_frame();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_on_error($sformatf("watchdog: the tests did not finish within %0d clock cycles",
                                watchdog_cycles));
    end

endmodule

`default_nettype wire

//--- all.f
verilog/mel_pkg.sv
verilog/stream_pkg.sv
verilog/mel_weight_seq.sv
verilog/mel_accumulate.sv
verilog/mel_band_collect.sv
verilog/mel_filter_bank.sv
sim/tb_mel_filter_bank.sv

//--- Makefile
TOP := tb_mel_filter_bank

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP) with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
